//--- mem1r1w_pkg.sv
package mem1r1w_pkg;

  parameter int NUM_LBNK = 4;
  parameter int NUM_PBNK = NUM_LBNK + 1;  // One spare physical bank
  parameter int NUM_ROWS = 16;
  parameter int WIDTH    = 16;

  parameter int LBNK_W = $clog2(NUM_LBNK);
  parameter int PBNK_W = $clog2(NUM_PBNK);
  parameter int ROW_W  = $clog2(NUM_ROWS);

  typedef logic [LBNK_W-1:0] lbnk_t;
  typedef logic [PBNK_W-1:0] pbnk_t;
  typedef logic [ROW_W-1:0]  row_t;
  typedef logic [WIDTH-1:0]  word_t;

  // Logical address, bank in the upper bits
  typedef struct packed {
    lbnk_t bank;
    row_t  row;
  } addr_t;

  // One row of the bank map
  typedef struct packed {
    pbnk_t [NUM_LBNK-1:0] pbnk;  // Physical bank per logical bank
    pbnk_t                free;  // Bank holding no live word in this row
  } map_entry_t;

  // One port of the bank array
  typedef struct packed {
    logic  en;
    logic  we;
    pbnk_t bank;
    row_t  row;
    word_t data;
  } bank_cmd_t;

  // Refresh command to the physical banks
  typedef struct packed {
    logic  vld;
    pbnk_t bank;
    row_t  row;
  } refr_cmd_t;

endpackage

//--- access_ctrl_fsm.sv
`timescale 1ns/10ps

module access_ctrl_fsm (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    write,
  input  mem1r1w_pkg::addr_t      wr_adr,
  input  mem1r1w_pkg::word_t      din,
  input  logic                    read,
  input  mem1r1w_pkg::addr_t      rd_adr,
  input  logic                    refr,
  input  mem1r1w_pkg::row_t       init_row,
  input  logic                    init_done,
  input  mem1r1w_pkg::pbnk_t      refr_bank,
  input  mem1r1w_pkg::row_t       refr_row,
  input  mem1r1w_pkg::map_entry_t wr_entry,
  input  mem1r1w_pkg::map_entry_t rd_entry,
  output mem1r1w_pkg::row_t       wr_row,
  output mem1r1w_pkg::row_t       rd_row,
  output logic                    map_we,
  output mem1r1w_pkg::row_t       map_row,
  output mem1r1w_pkg::map_entry_t map_wdata,
  output mem1r1w_pkg::bank_cmd_t  wr_cmd,
  output mem1r1w_pkg::bank_cmd_t  rd_cmd,
  output logic                    sweep_en,
  output logic                    refr_step,
  output mem1r1w_pkg::refr_cmd_t  refr_out,
  output logic                    ready,
  output logic                    rd_vld
);

  import mem1r1w_pkg::*;

  typedef enum logic {
    INIT = 1'b0,
    RUN  = 1'b1
  } state_t;

  state_t     state_q;
  state_t     state_d;
  logic       run;
  logic       wr_go;
  logic       rd_go;
  pbnk_t      wr_pbnk;
  pbnk_t      rd_pbnk;
  logic       conflict;
  pbnk_t      wr_tgt;
  map_entry_t ident_entry;
  map_entry_t remap_entry;

  assign run      = (state_q == RUN);
  assign ready    = run;
  assign sweep_en = !run;
  assign wr_go    = run && write;  // Strobes ignored during the sweep
  assign rd_go    = run && read;

  always_comb begin
    state_d = state_q;
    if (state_q == INIT && init_done) begin
      state_d = RUN;  // Last row is being written
    end
  end

  // Map lookups for both ports
  assign wr_row  = wr_adr.row;
  assign rd_row  = rd_adr.row;
  assign wr_pbnk = wr_entry.pbnk[wr_adr.bank];
  assign rd_pbnk = rd_entry.pbnk[rd_adr.bank];

  // Same physical bank can only mean different rows or the same address
  assign conflict = wr_go && rd_go && (wr_pbnk == rd_pbnk);
  assign wr_tgt   = conflict ? wr_entry.free : wr_pbnk;

  always_comb begin
    for (int i = 0; i < NUM_LBNK; i++) begin
      ident_entry.pbnk[i] = pbnk_t'(i);
    end
    ident_entry.free = pbnk_t'(NUM_LBNK);  // Spare bank starts free
  end

  always_comb begin
    remap_entry                   = wr_entry;
    remap_entry.pbnk[wr_adr.bank] = wr_entry.free;
    remap_entry.free              = wr_pbnk;  // Old copy is now stale
  end

  assign map_we    = sweep_en || conflict;
  assign map_row   = run ? wr_adr.row : init_row;
  assign map_wdata = run ? remap_entry : ident_entry;

  always_comb begin
    wr_cmd.en   = wr_go;
    wr_cmd.we   = wr_go;
    wr_cmd.bank = wr_tgt;
    wr_cmd.row  = wr_adr.row;
    wr_cmd.data = din;
  end

  always_comb begin
    rd_cmd.en   = rd_go;
    rd_cmd.we   = 1'b0;
    rd_cmd.bank = rd_pbnk;
    rd_cmd.row  = rd_adr.row;
    rd_cmd.data = '0;
  end

  assign refr_step = run && refr;  // Pointer moves with each issued refresh

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q  <= INIT;
      rd_vld   <= 1'b0;
      refr_out <= '0;
    end else begin
      state_q      <= state_d;
      rd_vld       <= rd_go;
      refr_out.vld <= refr_step;
      if (refr_step) begin
        refr_out.bank <= refr_bank;
        refr_out.row  <= refr_row;
      end
    end
  end

endmodule

//--- row_sweep_counter.sv
`timescale 1ns/10ps

module row_sweep_counter (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               sweep_en,
  input  logic               refr_step,
  output mem1r1w_pkg::row_t  init_row,
  output logic               init_done,
  output mem1r1w_pkg::pbnk_t refr_bank,
  output mem1r1w_pkg::row_t  refr_row
);

  import mem1r1w_pkg::*;

  localparam row_t  LAST_ROW  = row_t'(NUM_ROWS - 1);
  localparam pbnk_t LAST_BANK = pbnk_t'(NUM_PBNK - 1);

  // Counter sits on the last row once the sweep reaches it
  assign init_done = (init_row == LAST_ROW);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      init_row <= '0;
    end else if (sweep_en && !init_done) begin
      init_row <= init_row + 1'b1;
    end
  end

  // Bank steps first, row steps on bank wrap
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      refr_bank <= '0;
      refr_row  <= '0;
    end else if (refr_step) begin
      if (refr_bank == LAST_BANK) begin
        refr_bank <= '0;
        refr_row  <= (refr_row == LAST_ROW) ? '0 : refr_row + 1'b1;
      end else begin
        refr_bank <= refr_bank + 1'b1;
      end
    end
  end

endmodule

//--- bank_map.sv
`timescale 1ns/10ps

module bank_map #(
  parameter int NUM_LBNK = mem1r1w_pkg::NUM_LBNK,
  parameter int NUM_ROWS = mem1r1w_pkg::NUM_ROWS
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  mem1r1w_pkg::row_t       wr_row,
  input  mem1r1w_pkg::row_t       rd_row,
  input  logic                    map_we,
  input  mem1r1w_pkg::row_t       map_row,
  input  mem1r1w_pkg::map_entry_t map_wdata,
  output mem1r1w_pkg::map_entry_t wr_entry,
  output mem1r1w_pkg::map_entry_t rd_entry
);

  import mem1r1w_pkg::*;

  // One bank index per logical bank plus the free index
  localparam int ENTRY_W = (NUM_LBNK + 1) * $bits(pbnk_t);

  logic [ENTRY_W-1:0] map_mem [NUM_ROWS];

  // Two lookup ports, answered in the same cycle
  assign wr_entry = map_entry_t'(map_mem[wr_row]);
  assign rd_entry = map_entry_t'(map_mem[rd_row]);

  // Update lands on the edge, next lookup sees it
  always_ff @(posedge clk) begin
    if (rst_n && map_we) begin
      map_mem[map_row] <= map_wdata;
    end
  end

endmodule

//--- bank_array.sv
`timescale 1ns/10ps

module bank_array #(
  parameter int WIDTH    = mem1r1w_pkg::WIDTH,
  parameter int NUM_LBNK = mem1r1w_pkg::NUM_LBNK,
  parameter int NUM_ROWS = mem1r1w_pkg::NUM_ROWS
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  mem1r1w_pkg::bank_cmd_t wr_cmd,
  input  mem1r1w_pkg::bank_cmd_t rd_cmd,
  input  mem1r1w_pkg::refr_cmd_t refr_cmd,
  output mem1r1w_pkg::word_t     rd_dout
);

  import mem1r1w_pkg::*;

  localparam int NUM_BANKS = NUM_LBNK + 1;

  logic [WIDTH-1:0] bank_dout [NUM_BANKS];
  pbnk_t            rd_sel_q;

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    logic [WIDTH-1:0] mem [NUM_ROWS];
    logic [WIDTH-1:0] dout_q;
    logic             busy;
    logic             wr_hit;
    logic             rd_hit;

    // Bank under refresh takes no access this cycle
    assign busy   = refr_cmd.vld && (refr_cmd.bank == pbnk_t'(b));
    assign wr_hit = wr_cmd.en && wr_cmd.we && (wr_cmd.bank == pbnk_t'(b)) && !busy;
    assign rd_hit = rd_cmd.en && !rd_cmd.we && (rd_cmd.bank == pbnk_t'(b)) && !busy;

    // Single port, one access per cycle
    always_ff @(posedge clk) begin
      if (rst_n && wr_hit) begin
        mem[wr_cmd.row] <= wr_cmd.data;
      end else if (rd_hit) begin
        dout_q <= mem[rd_cmd.row];
      end
    end

    assign bank_dout[b] = dout_q;
  end

  // Remember which bank the read went to
  always_ff @(posedge clk) begin
    if (rd_cmd.en) begin
      rd_sel_q <= rd_cmd.bank;
    end
  end

  assign rd_dout = bank_dout[rd_sel_q];

endmodule

//--- mem1r1w_top.sv
`timescale 1ns/10ps

module mem1r1w_top #(
  parameter int WIDTH    = mem1r1w_pkg::WIDTH,
  parameter int NUM_LBNK = mem1r1w_pkg::NUM_LBNK,
  parameter int NUM_ROWS = mem1r1w_pkg::NUM_ROWS
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   write,
  input  mem1r1w_pkg::addr_t     wr_adr,
  input  mem1r1w_pkg::word_t     din,
  input  logic                   read,
  input  mem1r1w_pkg::addr_t     rd_adr,
  input  logic                   refr,
  output logic                   ready,
  output logic                   rd_vld,
  output mem1r1w_pkg::word_t     rd_dout,
  output mem1r1w_pkg::refr_cmd_t refr_out
);

  import mem1r1w_pkg::*;

  row_t       init_row;
  logic       init_done;
  pbnk_t      refr_bank;
  row_t       refr_row;
  logic       sweep_en;
  logic       refr_step;
  row_t       wr_row;
  row_t       rd_row;
  map_entry_t wr_entry;
  map_entry_t rd_entry;
  logic       map_we;
  row_t       map_row;
  map_entry_t map_wdata;
  bank_cmd_t  wr_cmd;
  bank_cmd_t  rd_cmd;

  access_ctrl_fsm ctrl_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .write     (write),
    .wr_adr    (wr_adr),
    .din       (din),
    .read      (read),
    .rd_adr    (rd_adr),
    .refr      (refr),
    .init_row  (init_row),
    .init_done (init_done),
    .refr_bank (refr_bank),
    .refr_row  (refr_row),
    .wr_entry  (wr_entry),
    .rd_entry  (rd_entry),
    .wr_row    (wr_row),
    .rd_row    (rd_row),
    .map_we    (map_we),
    .map_row   (map_row),
    .map_wdata (map_wdata),
    .wr_cmd    (wr_cmd),
    .rd_cmd    (rd_cmd),
    .sweep_en  (sweep_en),
    .refr_step (refr_step),
    .refr_out  (refr_out),
    .ready     (ready),
    .rd_vld    (rd_vld)
  );

  row_sweep_counter sweep_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .sweep_en  (sweep_en),
    .refr_step (refr_step),
    .init_row  (init_row),
    .init_done (init_done),
    .refr_bank (refr_bank),
    .refr_row  (refr_row)
  );

  bank_map #(
    .NUM_LBNK (NUM_LBNK),
    .NUM_ROWS (NUM_ROWS)
  ) map_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr_row    (wr_row),
    .rd_row    (rd_row),
    .map_we    (map_we),
    .map_row   (map_row),
    .map_wdata (map_wdata),
    .wr_entry  (wr_entry),
    .rd_entry  (rd_entry)
  );

  bank_array #(
    .WIDTH    (WIDTH),
    .NUM_LBNK (NUM_LBNK),
    .NUM_ROWS (NUM_ROWS)
  ) array_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr_cmd   (wr_cmd),
    .rd_cmd   (rd_cmd),
    .refr_cmd (refr_out),
    .rd_dout  (rd_dout)
  );

endmodule

//--- tb_mem1r1w.sv
`timescale 1ns/10ps

module tb_mem1r1w;

  import mem1r1w_pkg::*;

  localparam int NUM_ADDR      = NUM_LBNK * NUM_ROWS;
  localparam int READY_TIMEOUT = NUM_ROWS + 2;
  localparam int RAND_CYCLES   = 400;
  localparam int REFR_COUNT    = NUM_PBNK * NUM_ROWS + 20;  // More than one full wrap

  logic      clk;
  logic      rst_n;
  logic      write;
  addr_t     wr_adr;
  word_t     din;
  logic      read;
  addr_t     rd_adr;
  logic      refr;
  logic      ready;
  logic      rd_vld;
  word_t     rd_dout;
  refr_cmd_t refr_out;

  logic   armed;
  logic   ready_seen;
  string  test_name;
  integer seed;
  int     reads_issued;
  int     refr_issued;
  word_t  model [NUM_ADDR];  // Expected contents by logical address
  word_t  rd_exp_word;

  logic  exp_vld_q;
  word_t exp_word_q;
  logic  exp_refr_vld_q;
  pbnk_t exp_refr_bank_q;
  row_t  exp_refr_row_q;
  pbnk_t ptr_bank;
  row_t  ptr_row;
  int    reads_checked;
  int    refr_seen;

  mem1r1w_top #(
    .WIDTH    (WIDTH),
    .NUM_LBNK (NUM_LBNK),
    .NUM_ROWS (NUM_ROWS)
  ) dut_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .write    (write),
    .wr_adr   (wr_adr),
    .din      (din),
    .read     (read),
    .rd_adr   (rd_adr),
    .refr     (refr),
    .ready    (ready),
    .rd_vld   (rd_vld),
    .rd_dout  (rd_dout),
    .refr_out (refr_out)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Expected responses one cycle after each strobe, strobes are only sent once ready
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exp_vld_q       <= 1'b0;
      exp_word_q      <= '0;
      exp_refr_vld_q  <= 1'b0;
      exp_refr_bank_q <= '0;
      exp_refr_row_q  <= '0;
      ptr_bank        <= '0;
      ptr_row         <= '0;
      reads_checked   <= 0;
      refr_seen       <= 0;
    end else begin
      exp_vld_q      <= read;
      exp_word_q     <= rd_exp_word;
      exp_refr_vld_q <= refr;
      if (exp_vld_q) begin
        reads_checked <= reads_checked + 1;
      end
      if (exp_refr_vld_q) begin
        refr_seen <= refr_seen + 1;
      end
      if (refr) begin
        exp_refr_bank_q <= ptr_bank;
        exp_refr_row_q  <= ptr_row;
        if (int'(ptr_bank) == NUM_PBNK - 1) begin  // Bank wraps first, then row
          ptr_bank <= '0;
          ptr_row  <= (int'(ptr_row) == NUM_ROWS - 1) ? '0 : ptr_row + 1'b1;
        end else begin
          ptr_bank <= ptr_bank + 1'b1;
        end
      end
    end
  end

  task automatic report_and_stop(input string line);
    $display("%s", line);
    $display("Test failed");
    $fatal(1, "Simulation stopped on error");
  endtask

  reset_state_check: assert property (@(posedge clk) disable iff (!armed)
    rst_n || (!ready && !rd_vld && !refr_out.vld))
    else report_and_stop($sformatf("FAILED %s ready/rd_vld/refr_vld: expected 000, actual %b%b%b",
      test_name, $sampled(ready), $sampled(rd_vld), $sampled(refr_out.vld)));

  ready_hold_check: assert property (@(posedge clk) disable iff (!armed || !rst_n)
    !ready_seen || ready)
    else report_and_stop($sformatf("FAILED %s ready: expected 1, actual 0", test_name));

  rd_vld_check: assert property (@(posedge clk) disable iff (!armed || !rst_n)
    rd_vld == exp_vld_q)
    else report_and_stop($sformatf("FAILED %s rd_vld: expected %0b, actual %0b",
      test_name, $sampled(exp_vld_q), $sampled(rd_vld)));

  rd_data_check: assert property (@(posedge clk) disable iff (!armed || !rst_n)
    !exp_vld_q || rd_dout == exp_word_q)
    else report_and_stop($sformatf("FAILED %s rd_dout: expected %h, actual %h",
      test_name, $sampled(exp_word_q), $sampled(rd_dout)));

  refr_vld_check: assert property (@(posedge clk) disable iff (!armed || !rst_n)
    refr_out.vld == exp_refr_vld_q)
    else report_and_stop($sformatf("FAILED %s refr_out.vld: expected %0b, actual %0b",
      test_name, $sampled(exp_refr_vld_q), $sampled(refr_out.vld)));

  refr_ptr_check: assert property (@(posedge clk) disable iff (!armed || !rst_n)
    !exp_refr_vld_q || (refr_out.bank == exp_refr_bank_q && refr_out.row == exp_refr_row_q))
    else report_and_stop($sformatf("FAILED %s refr_out bank/row: expected %0d/%0d, actual %0d/%0d",
      test_name, $sampled(exp_refr_bank_q), $sampled(exp_refr_row_q),
      $sampled(refr_out.bank), $sampled(refr_out.row)));

  function automatic word_t fill_word(input addr_t a);
    logic [$bits(addr_t)-1:0] bits;
    bits = a;
    return word_t'({2'b10, ~bits, bits, 2'b01});
  endfunction

  // One clock cycle of stimulus, model updated after the read is taken
  task automatic drive_cycle(input logic do_wr, input addr_t wa, input word_t wd,
                             input logic do_rd, input addr_t ra, input logic do_refr);
    write  <= do_wr;
    wr_adr <= wa;
    din    <= wd;
    read   <= do_rd;
    rd_adr <= ra;
    refr   <= do_refr;
    if (do_rd) begin
      rd_exp_word <= model[ra];
      reads_issued++;
    end
    if (do_wr) begin
      model[wa] = wd;
    end
    if (do_refr) begin
      refr_issued++;
    end
    @(posedge clk);
  endtask

  task automatic idle_cycle();
    drive_cycle(1'b0, '0, '0, 1'b0, '0, 1'b0);
  endtask

  task automatic read_all();
    addr_t ra;
    for (int a = 0; a < NUM_ADDR; a++) begin
      ra = addr_t'(a);
      drive_cycle(1'b0, '0, '0, 1'b1, ra, 1'b0);
    end
  endtask

  initial begin
    int    cnt;
    int    rnd;
    int    rnd_data;
    addr_t wa;
    addr_t ra;
    logic  do_wr;
    logic  do_rd;
    logic  do_refr;
    logic  prev_refr;
    seed         = 23420;
    test_name    = "reset";
    reads_issued = 0;
    refr_issued  = 0;
    rst_n       <= 1'b1;
    write       <= 1'b0;
    wr_adr      <= '0;
    din         <= '0;
    read        <= 1'b0;
    rd_adr      <= '0;
    refr        <= 1'b0;
    armed       <= 1'b0;
    ready_seen  <= 1'b0;
    rd_exp_word <= '0;

    @(posedge clk);
    rst_n <= 1'b0;
    armed <= 1'b1;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    test_name = "startup";
    cnt = 0;
    while (!ready && cnt < READY_TIMEOUT) begin
      cnt++;
      @(posedge clk);
    end
    if (!ready) begin
      report_and_stop($sformatf("ready did not rise within %0d cycles after reset",
        READY_TIMEOUT));
    end
    ready_seen <= 1'b1;

    test_name = "fill";
    for (int a = 0; a < NUM_ADDR; a++) begin
      wa = addr_t'(a);
      drive_cycle(1'b1, wa, fill_word(wa), 1'b0, '0, 1'b0);
    end
    read_all();

    // Same logical bank in two rows, so both land on one physical bank
    test_name = "collide";
    for (int b = 0; b < NUM_LBNK; b++) begin
      wa.bank = lbnk_t'(b);
      wa.row  = row_t'(2 * b);
      ra.bank = lbnk_t'(b);
      ra.row  = row_t'(2 * b + 1);
      rnd = $random(seed);
      drive_cycle(1'b1, wa, word_t'(rnd), 1'b1, ra, 1'b0);
    end
    for (int b = 0; b < NUM_LBNK; b++) begin
      wa.bank = lbnk_t'(b);
      wa.row  = row_t'(2 * b);
      rnd = $random(seed);
      drive_cycle(1'b1, wa, word_t'(rnd), 1'b1, wa, 1'b0);  // Old word comes back
    end
    read_all();

    test_name = "random";
    prev_refr = 1'b0;
    for (int i = 0; i < RAND_CYCLES; i++) begin
      rnd      = $random(seed);
      rnd_data = $random(seed);
      wa       = addr_t'(rnd[13:8]);
      ra       = (rnd[7:5] == 3'd0) ? wa : addr_t'(rnd[19:14]);
      do_wr    = rnd[0] && !prev_refr;  // Bank is busy in the cycle after a refresh
      do_rd    = rnd[1] && !prev_refr;
      do_refr  = !do_wr && !do_rd && rnd[2];
      drive_cycle(do_wr, wa, word_t'(rnd_data), do_rd, ra, do_refr);
      prev_refr = do_refr;
    end

    test_name = "refresh";
    cnt = 0;
    while (cnt < REFR_COUNT) begin
      rnd = $random(seed);
      if (rnd[1:0] == 2'd0) begin
        idle_cycle();
      end else begin
        drive_cycle(1'b0, '0, '0, 1'b0, '0, 1'b1);
        cnt++;
      end
    end
    idle_cycle();
    read_all();

    test_name = "drain";
    repeat (3) idle_cycle();
    if (reads_checked != reads_issued || refr_seen != refr_issued) begin
      report_and_stop($sformatf("Only %0d of %0d reads and %0d of %0d refreshes were checked",
        reads_checked, reads_issued, refr_seen, refr_issued));
    end else begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule

//--- project.f
mem1r1w_pkg.sv
access_ctrl_fsm.sv
row_sweep_counter.sv
bank_map.sv
bank_array.sv
mem1r1w_top.sv
tb_mem1r1w.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/10ps --top-module tb_mem1r1w \
  -f project.f -o sim_mem1r1w

./obj_dir/sim_mem1r1w > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
  exit 1
fi
